/* list.f */
+incdir+common
common/mem_types_pkg.sv
common/ctrl_types_pkg.sv
common/cacheline_itf.sv
arbiter/arbiter.sv
rtl/burst_adapter.sv
rtl/mem_subsystem_top.sv
verification/tb_mem_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_mem_subsystem -o tb_mem_subsystem > build.log 2>&1 \
    && ./obj_dir/tb_mem_subsystem > "$LOG" 2>&1

grep -q "^TB PASSED$" "$LOG" 2>/dev/null \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see $LOG and build.log"; exit 1; }

/* verification/tb_mem_subsystem.sv */
`timescale 1ns/1ps
`include "arbiter_defines.svh"

module tb_mem_subsystem;

    localparam int CLK_PERIOD  = 100;
    localparam int N_TRANS     = 60;
    localparam int N_LINES     = 8;
    localparam int WATCHDOG_NS = 200 * N_TRANS * CLK_PERIOD;

    logic clk = 1'b0;
    logic rst;
    logic icache_read, icache_ready, dcache_read, dcache_write, dcache_ready;
    logic line_rvalid, mem_read, mem_write, mem_resp;
    mem_types_pkg::addr_t icache_addr, dcache_addr, line_raddr, mem_addr;
    mem_types_pkg::line_t dcache_wdata, line_rdata;
    mem_types_pkg::beat_t mem_wdata, mem_rdata;

    // memory model and reference line store.
    mem_types_pkg::beat_t mem_beats [N_LINES * `ARB_BEATS];
    mem_types_pkg::line_t ref_lines [N_LINES];
    int beat_n, wait_left;
    logic bus_active;

    // bus monitor state, all updated on the clock edge.
    logic seen_req, busy, prev_mem_write;
    logic [2:0] wr_beats;
    mem_types_pkg::addr_t wr_addr_q, rd_addr_q;
    mem_types_pkg::line_t wr_line_q;
    int read_accepts, rvalid_count;

    mem_subsystem_top dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // beat k of a line is bits 64k up to 64k+63.
    function automatic mem_types_pkg::beat_t line_beat(mem_types_pkg::line_t l, int k);
        return l[k * `ARB_BEAT_W +: `ARB_BEAT_W];
    endfunction

    // initial memory contents, a function of the beat address.
    function automatic mem_types_pkg::beat_t fill_beat(int idx);
        logic [31:0] a;
        a = 32'(idx);
        return {a * 32'h9e3779b9, a ^ 32'h5a5a5a5a};
    endfunction

    function automatic mem_types_pkg::addr_t random_addr();
        mem_types_pkg::addr_t a;
        a = '0;
        a[7:5] = 3'($urandom % N_LINES);
        return a;
    endfunction

    function automatic mem_types_pkg::line_t random_line();
        mem_types_pkg::line_t l;
        for (int w = 0; w < 8; w++) begin
            l[w * 32 +: 32] = $urandom;
        end
        return l;
    endfunction

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // ------------------------------
    // memory model.
    // ------------------------------

    // each beat is answered 0 to 3 cycles after the previous one.
    always @(posedge clk) begin
        if (rst) begin
            mem_resp  <= 1'b0;
            mem_rdata <= '0;
            beat_n    = 0;
            wait_left = -1;
        end else begin
            bus_active = mem_read || mem_write;
            if (bus_active && mem_resp) begin
                if (mem_write) begin
                    mem_beats[int'(mem_addr[7:5]) * `ARB_BEATS + beat_n] <= mem_wdata;
                end
                beat_n = beat_n + 1;
            end
            if (!bus_active) begin
                beat_n    = 0;
                wait_left = -1;
            end
            mem_resp <= 1'b0;
            if (bus_active && beat_n < `ARB_BEATS) begin
                if (wait_left < 0) begin
                    wait_left = int'($urandom % 4);
                end
                if (wait_left == 0) begin
                    mem_resp  <= 1'b1;
                    mem_rdata <= mem_beats[int'(mem_addr[7:5]) * `ARB_BEATS + beat_n];
                    wait_left = -1;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    // ------------------------------
    // bus monitor.
    // ------------------------------

    always @(posedge clk) begin
        if (rst) begin
            seen_req       <= 1'b0;
            busy           <= 1'b0;
            prev_mem_write <= 1'b0;
            wr_beats       <= '0;
            read_accepts   <= 0;
            rvalid_count   <= 0;
        end else begin
            prev_mem_write <= mem_write;
            if (icache_read || dcache_read || dcache_write) begin
                seen_req <= 1'b1;
            end
            if (dcache_ready && dcache_write) begin
                wr_addr_q <= dcache_addr;
                wr_line_q <= dcache_wdata;
                wr_beats  <= '0;
                busy      <= 1'b1;
            end else if (dcache_ready && dcache_read) begin
                rd_addr_q    <= dcache_addr;
                read_accepts <= read_accepts + 1;
                busy         <= 1'b1;
            end else if (icache_ready && icache_read) begin
                rd_addr_q    <= icache_addr;
                read_accepts <= read_accepts + 1;
                busy         <= 1'b1;
            end
            if (mem_write && mem_resp) begin
                wr_beats <= wr_beats + 3'd1;
            end
            if (line_rvalid) begin
                busy         <= 1'b0;
                rvalid_count <= rvalid_count + 1;
            end
            // end of the write_done cycle.
            if (prev_mem_write && !mem_write) begin
                busy <= 1'b0;
                ref_lines[wr_addr_q[7:5]] <= wr_line_q;
            end
        end
    end

    // ------------------------------
    // checks.
    // ------------------------------

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !(seen_req || icache_read || dcache_read || dcache_write)
        |-> !(mem_read || mem_write || line_rvalid || icache_ready || dcache_ready))
        else begin
            $display({"** Error at %0t: mem_read/mem_write/line_rvalid/icache_ready/",
                "dcache_ready expected 00000, got %b"},
                $time, {mem_read, mem_write, line_rvalid, icache_ready, dcache_ready});
            abort_run();
        end

    a_dcache_first: assert property (@(posedge clk) disable iff (rst)
        (icache_read && (dcache_read || dcache_write) && (icache_ready || dcache_ready))
        |-> (dcache_ready && !icache_ready))
        else begin
            $display("** Error at %0t: dcache_ready/icache_ready expected 1/0, got %b/%b",
                $time, dcache_ready, icache_ready);
            abort_run();
        end

    a_no_grant_busy: assert property (@(posedge clk) disable iff (rst)
        busy |-> !(icache_ready || dcache_ready))
        else begin
            $display("** Error at %0t: icache_ready/dcache_ready expected 0/0, got %b/%b",
                $time, icache_ready, dcache_ready);
            abort_run();
        end

    a_write_beat: assert property (@(posedge clk) disable iff (rst)
        (mem_write && mem_resp) |-> (wr_beats < 3'd4 && mem_addr == wr_addr_q
        && mem_wdata == line_beat(wr_line_q, int'(wr_beats[1:0]))))
        else begin
            $display("** Error at %0t: beat %0d mem_addr expected %h, got %h", $time,
                wr_beats, wr_addr_q, mem_addr);
            $display("** Error at %0t: mem_wdata expected %h, got %h", $time,
                line_beat(wr_line_q, int'(wr_beats[1:0])), mem_wdata);
            abort_run();
        end

    a_write_four_beats: assert property (@(posedge clk) disable iff (rst)
        (prev_mem_write && !mem_write) |-> wr_beats == 3'd4)
        else begin
            $display("** Error at %0t: write beat count expected 4, got %0d", $time, wr_beats);
            abort_run();
        end

    a_read_line: assert property (@(posedge clk) disable iff (rst)
        line_rvalid |-> (line_raddr == rd_addr_q && line_rdata == ref_lines[rd_addr_q[7:5]]))
        else begin
            $display("** Error at %0t: line_raddr expected %h, got %h", $time,
                rd_addr_q, line_raddr);
            $display("** Error at %0t: line_rdata expected %h, got %h", $time,
                ref_lines[rd_addr_q[7:5]], line_rdata);
            abort_run();
        end

    // ------------------------------
    // stimulus.
    // ------------------------------

    // raises the chosen requests and drops each one after its ready.
    task automatic issue_requests(input logic use_i, input logic use_d, input logic d_write);
        logic pend_i;
        logic pend_d;
        pend_i = use_i;
        pend_d = use_d;
        @(posedge clk);
        icache_read  <= use_i;
        icache_addr  <= random_addr();
        dcache_read  <= use_d && !d_write;
        dcache_write <= use_d && d_write;
        dcache_addr  <= random_addr();
        dcache_wdata <= random_line();
        while (pend_i || pend_d) begin
            @(posedge clk);
            if (pend_d && dcache_ready) begin
                dcache_read  <= 1'b0;
                dcache_write <= 1'b0;
                pend_d = 1'b0;
            end
            if (pend_i && icache_ready) begin
                icache_read <= 1'b0;
                pend_i = 1'b0;
            end
        end
    endtask

    initial begin
        int kind;
        void'($urandom(32'hf67a8858));
        for (int i = 0; i < N_LINES * `ARB_BEATS; i++) begin
            mem_beats[i] = fill_beat(i);
            ref_lines[i / `ARB_BEATS][(i % `ARB_BEATS) * `ARB_BEAT_W +: `ARB_BEAT_W] =
                fill_beat(i);
        end
        rst          = 1'b1;
        icache_read  = 1'b0;
        icache_addr  = '0;
        dcache_read  = 1'b0;
        dcache_write = 1'b0;
        dcache_addr  = '0;
        dcache_wdata = '0;
        mem_resp     = 1'b0;
        mem_rdata    = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        for (int t = 0; t < N_TRANS; t++) begin
            kind = int'($urandom % 4);
            case (kind)
                0: issue_requests(1'b1, 1'b0, 1'b0);
                1: issue_requests(1'b0, 1'b1, 1'b0);
                2: issue_requests(1'b0, 1'b1, 1'b1);
                default: issue_requests(1'b1, 1'b1, 1'($urandom % 2));
            endcase
            repeat ($urandom % 3) @(posedge clk);
        end
        // let the last transaction finish.
        @(posedge clk);
        while (busy) begin
            @(posedge clk);
        end
        @(posedge clk);
        if (rvalid_count == read_accepts) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("** Error at %0t: rvalid_count expected %0d, got %0d", $time,
                read_accepts, rvalid_count);
            abort_run();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the transactions did not finish in time");
        abort_run();
    end

endmodule

/* rtl/mem_subsystem_top.sv */
`timescale 1ns/1ps
`include "arbiter_defines.svh"

module mem_subsystem_top (
    input  logic                 clk,
    input  logic                 rst,

    // icache side.
    input  logic                 icache_read,
    input  mem_types_pkg::addr_t icache_addr,
    output logic                 icache_ready,

    // dcache side.
    input  logic                 dcache_read,
    input  logic                 dcache_write,
    input  mem_types_pkg::addr_t dcache_addr,
    input  mem_types_pkg::line_t dcache_wdata,
    output logic                 dcache_ready,

    // response shared by both caches.
    output mem_types_pkg::line_t line_rdata,
    output logic                 line_rvalid,
    output mem_types_pkg::addr_t line_raddr,

    // memory bus.
    output logic                 mem_read,
    output logic                 mem_write,
    output mem_types_pkg::addr_t mem_addr,
    output mem_types_pkg::beat_t mem_wdata,
    input  mem_types_pkg::beat_t mem_rdata,
    input  logic                 mem_resp
);

    cacheline_itf icache_itf ();
    cacheline_itf dcache_itf ();
    cacheline_itf adapter_itf ();

    // the icache only reads.
    assign icache_itf.read  = icache_read;
    assign icache_itf.write = 1'b0;
    assign icache_itf.addr  = icache_addr;
    assign icache_itf.wdata = '0;
    assign icache_ready     = icache_itf.ready;

    assign dcache_itf.read  = dcache_read;
    assign dcache_itf.write = dcache_write;
    assign dcache_itf.addr  = dcache_addr;
    assign dcache_itf.wdata = dcache_wdata;
    assign dcache_ready     = dcache_itf.ready;

    // both copies carry the same response.
    assign line_rdata  = dcache_itf.rdata;
    assign line_rvalid = dcache_itf.rvalid;
    assign line_raddr  = dcache_itf.raddr;

    arbiter u_arbiter (
        .clk     (clk),
        .rst     (rst),
        .icache  (icache_itf.slave),
        .dcache  (dcache_itf.slave),
        .adapter (adapter_itf.master)
    );

    burst_adapter u_burst_adapter (
        .clk       (clk),
        .rst       (rst),
        .line      (adapter_itf.slave),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp)
    );

endmodule

/* rtl/burst_adapter.sv */
`timescale 1ns/1ps
`include "arbiter_defines.svh"

module burst_adapter (
    input  logic                 clk,
    input  logic                 rst,

    cacheline_itf.slave          line,

    output logic                 mem_read,
    output logic                 mem_write,
    output mem_types_pkg::addr_t mem_addr,
    output mem_types_pkg::beat_t mem_wdata,
    input  mem_types_pkg::beat_t mem_rdata,
    input  logic                 mem_resp
);

    localparam mem_types_pkg::beat_idx_t last_beat =
        mem_types_pkg::beat_idx_t'(`ARB_BEATS - 1);

    ctrl_types_pkg::adapter_state_e state;
    ctrl_types_pkg::adapter_state_e state_next;

    mem_types_pkg::beat_idx_t beat_cnt;
    mem_types_pkg::addr_t     addr_q;
    mem_types_pkg::line_t     line_q;

    logic accept;
    logic in_burst;
    logic last_resp;

    // ----------------------------
    // handshake with the arbiter.
    // ----------------------------

    // write_done also shows ready, that is how the arbiter sees the end of a write.
    assign line.ready = (state == ctrl_types_pkg::idle) ||
                        (state == ctrl_types_pkg::write_done);

    assign accept = (state == ctrl_types_pkg::idle) && (line.read || line.write);

    assign in_burst = (state == ctrl_types_pkg::read_burst) ||
                      (state == ctrl_types_pkg::write_burst);

    assign last_resp = in_burst && mem_resp && (beat_cnt == last_beat);

    // ----------------------------
    // FSM.
    // ----------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ctrl_types_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ctrl_types_pkg::idle: begin
                if (line.write) begin
                    state_next = ctrl_types_pkg::write_burst;
                end else if (line.read) begin
                    state_next = ctrl_types_pkg::read_burst;
                end
            end
            ctrl_types_pkg::read_burst: begin
                if (last_resp) begin
                    state_next = ctrl_types_pkg::read_done;
                end
            end
            ctrl_types_pkg::read_done: begin
                state_next = ctrl_types_pkg::idle;
            end
            ctrl_types_pkg::write_burst: begin
                if (last_resp) begin
                    state_next = ctrl_types_pkg::write_done;
                end
            end
            // commands seen here are the tail of the replayed write.
            ctrl_types_pkg::write_done: begin
                state_next = ctrl_types_pkg::idle;
            end
            default: state_next = ctrl_types_pkg::idle;
        endcase
    end

    // beat counter wraps to zero after the last beat.
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (accept) begin
            beat_cnt <= '0;
        end else if (in_burst && mem_resp) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // ----------------------------
    // datapath.
    // ----------------------------

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= line.addr;
        end
        if (state == ctrl_types_pkg::read_burst && mem_resp) begin
            line_q[int'(beat_cnt) * `ARB_BEAT_W +: `ARB_BEAT_W] <= mem_rdata;
        end
    end

    assign mem_read  = (state == ctrl_types_pkg::read_burst);
    assign mem_write = (state == ctrl_types_pkg::write_burst);
    assign mem_addr  = addr_q;

    // the arbiter holds the line, so pick the beat straight from it.
    assign mem_wdata = line.wdata[int'(beat_cnt) * `ARB_BEAT_W +: `ARB_BEAT_W];

    assign line.rvalid = (state == ctrl_types_pkg::read_done);
    assign line.rdata  = line_q;
    assign line.raddr  = addr_q;

    // ----------------------------
    // assertions.
    // ----------------------------

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(line.read && line.write));

    a_wdata_held: assert property (@(posedge clk) disable iff (rst)
        (mem_write && !mem_resp) |=> $stable(mem_wdata));

endmodule

/* arbiter/arbiter.sv */
`timescale 1ns/1ps
`include "arbiter_defines.svh"

module arbiter (
    input  logic         clk,
    input  logic         rst,

    cacheline_itf.slave  icache,
    cacheline_itf.slave  dcache,
    cacheline_itf.master adapter
);

    ctrl_types_pkg::arb_state_e state;
    ctrl_types_pkg::arb_state_e state_next;

    logic icache_req;
    logic dcache_req;
    logic can_grant;
    logic grant_i;
    logic grant_d;

    mem_types_pkg::addr_t addr_buf;
    mem_types_pkg::line_t data_buf;

    // ----------------------------
    // grant logic.
    // ----------------------------

    assign icache_req = icache.read | icache.write;
    assign dcache_req = dcache.read | dcache.write;

    // only grant when the adapter is idle and no write is being replayed.
    assign can_grant = (state == ctrl_types_pkg::pass_thru) && adapter.ready;

    // dcache has fixed priority over icache.
    assign grant_d = can_grant && dcache_req;
    assign grant_i = can_grant && icache_req && !dcache_req;

    assign dcache.ready = grant_d;
    assign icache.ready = grant_i;

    // ----------------------------
    // write buffer.
    // ----------------------------

    // the requester drops wdata after the grant, so keep a copy.
    always_ff @(posedge clk) begin
        if (grant_d && dcache.write) begin
            addr_buf <= dcache.addr;
            data_buf <= dcache.wdata;
        end else if (grant_i && icache.write) begin
            addr_buf <= icache.addr;
            data_buf <= icache.wdata;
        end
    end

    // ----------------------------
    // FSM.
    // ----------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ctrl_types_pkg::pass_thru;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ctrl_types_pkg::pass_thru: begin
                if ((grant_d && dcache.write) || (grant_i && icache.write)) begin
                    state_next = ctrl_types_pkg::wait_write;
                end
            end
            ctrl_types_pkg::wait_write: begin
                // ready comes back in the adapter's write_done cycle.
                if (adapter.ready) begin
                    state_next = ctrl_types_pkg::pass_thru;
                end
            end
            default: state_next = ctrl_types_pkg::pass_thru;
        endcase
    end

    // request towards the adapter.
    always_comb begin
        adapter.read  = 1'b0;
        adapter.write = 1'b0;
        adapter.addr  = '0;
        adapter.wdata = '0;
        if (state == ctrl_types_pkg::wait_write) begin
            adapter.write = 1'b1;
            adapter.addr  = addr_buf;
            adapter.wdata = data_buf;
        end else if (grant_d) begin
            adapter.read  = dcache.read;
            adapter.write = dcache.write;
            adapter.addr  = dcache.addr;
            adapter.wdata = dcache.wdata;
        end else if (grant_i) begin
            adapter.read  = icache.read;
            adapter.write = icache.write;
            adapter.addr  = icache.addr;
            adapter.wdata = icache.wdata;
        end
    end

    // responses go to both caches, each one matches on raddr.
    assign icache.rdata  = adapter.rdata;
    assign icache.rvalid = adapter.rvalid;
    assign icache.raddr  = adapter.raddr;
    assign dcache.rdata  = adapter.rdata;
    assign dcache.rvalid = adapter.rvalid;
    assign dcache.raddr  = adapter.raddr;

    // ----------------------------
    // assertions.
    // ----------------------------

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        (icache.ready || dcache.ready) |=> !(icache.ready || dcache.ready));

    a_buf_stable: assert property (@(posedge clk) disable iff (rst)
        (state == ctrl_types_pkg::wait_write)
        |-> ($stable(adapter.addr) && $stable(adapter.wdata)));

endmodule

/* common/cacheline_itf.sv */
`timescale 1ns/1ps

interface cacheline_itf;

    // request side, held until ready.
    logic                 read;
    logic                 write;
    mem_types_pkg::addr_t addr;
    mem_types_pkg::line_t wdata;

    // response side.
    logic                 ready;
    mem_types_pkg::line_t rdata;
    logic                 rvalid;
    mem_types_pkg::addr_t raddr;

    modport master (
        output read,
        output write,
        output addr,
        output wdata,
        input  ready,
        input  rdata,
        input  rvalid,
        input  raddr
    );

    modport slave (
        input  read,
        input  write,
        input  addr,
        input  wdata,
        output ready,
        output rdata,
        output rvalid,
        output raddr
    );

endinterface

/* common/ctrl_types_pkg.sv */
package ctrl_types_pkg;

    // arbiter states.
    typedef enum logic [0:0] {
        pass_thru,
        wait_write
    } arb_state_e;

    // burst adapter states.
    typedef enum logic [2:0] {
        idle,
        read_burst,
        read_done,
        write_burst,
        write_done
    } adapter_state_e;

endpackage

/* common/mem_types_pkg.sv */
`include "arbiter_defines.svh"

package mem_types_pkg;

    // ----------------------------
    // data types on the memory side.
    // ----------------------------

    // line address, low five bits are always zero.
    typedef logic [`ARB_ADDR_W-1:0] addr_t;

    // full cache line.
    typedef logic [`ARB_LINE_W-1:0] line_t;

    // one bus beat, two words.
    typedef logic [`ARB_BEAT_W-1:0] beat_t;

    // counts beats within one burst.
    typedef logic [$clog2(`ARB_BEATS)-1:0] beat_idx_t;

endpackage

/* common/arbiter_defines.svh */
`ifndef ARBITER_DEFINES_SVH
`define ARBITER_DEFINES_SVH

// ----------------------------
// memory side widths.
// ----------------------------

// byte address width.
`define ARB_ADDR_W 32

// one cache line is eight 32-bit words.
`define ARB_LINE_W 256

// one beat on the memory bus.
`define ARB_BEAT_W 64

// beats needed to move one line.
`define ARB_BEATS 4

`endif
